//--- hdl/f100_defines.svh
// F100-L core constants.
// Word and field widths, the reset vector, the halt code inside
// opcode 0 and the number of sequencer states.

`ifndef F100_DEFINES_SVH
`define F100_DEFINES_SVH

// Data and address width.
`define F100_WORD_W 16

// Short address field of the ALU instruction format.
`define F100_SHORT_W 11

// First instruction fetched after reset.
`define F100_RESET_PC 16'h2000

// Bits 11:10 of an opcode 0 word that stop the core.
`define F100_HALT_CODE 2'b01

// States of the instruction sequencer.
`define F100_STATE_COUNT 10

`endif

//--- hdl/f100_pkg.sv
// F100-L shared types.
// Machine word, the two views of an instruction word, the condition
// register layout, the memory bus request and the ALU flag bundle.

package f100_pkg;

  // One machine word.
  typedef logic [15:0] word_t;

  // Top four bits of every instruction.
  typedef enum logic [3:0]
  {
    OP_BIT = 4'h0,
    OP_STO = 4'h4,
    OP_ADS = 4'h5,
    OP_SBS = 4'h6,
    OP_LDA = 4'h8,
    OP_ADD = 4'h9,
    OP_SUB = 4'ha,
    OP_CMP = 4'hb,
    OP_AND = 4'hc,
    OP_NEQ = 4'hd,
    OP_JMP = 4'hf
  } alu_op_e;

  // Memory reference format. Bits 7:0 of addr hold the pointer.
  typedef struct packed {
    alu_op_e     op;
    logic        indirect;
    logic [10:0] addr;
  } alu_fmt_t;

  // Shift, bit jump and bit set or clear format.
  typedef struct packed {
    alu_op_e    op;
    logic [1:0] sub;
    logic [1:0] r_mode;
    logic [1:0] s_mode;
    logic [1:0] j_mode;
    logic [3:0] bit_idx;
  } bit_fmt_t;

  typedef union packed {
    alu_fmt_t alu;
    bit_fmt_t bits;
  } instr_t;

  // Condition register.
  typedef struct packed {
    logic [8:0] unused;
    logic       f;
    logic       m;
    logic       c;
    logic       s;
    logic       v;
    logic       z;
    logic       i;
  } cr_t;

  typedef struct packed {
    word_t address;
    word_t wdata;
    logic  bus_enable;
    logic  write_enable;
  } mem_req_t;

  typedef struct packed {
    logic carry;
    logic sign;
    logic zero;
    logic overflow;
  } alu_flags_t;

endpackage

//--- hdl/f100_alu.sv
// F100-L single-length ALU.
// Adds, subtracts and compares with optional carry, does AND and
// exclusive-or, and passes operands through for loads, stores and jumps.
// Reports carry, sign, zero and overflow for the result.

`timescale 1ns/1ps
`include "f100_defines.svh"

module f100_alu
(
  input  f100_pkg::alu_op_e    op,
  input  f100_pkg::word_t      a,
  input  f100_pkg::word_t      d,
  input  logic                 m,
  input  logic                 c,
  output f100_pkg::word_t      result,
  output f100_pkg::alu_flags_t flags
);

  localparam int MSB = `F100_WORD_W - 1;

  logic [`F100_WORD_W:0] sum;
  logic                  is_add;
  logic                  is_sub;

  always_comb
  begin
    is_add = (op == f100_pkg::OP_ADD) || (op == f100_pkg::OP_ADS);
    is_sub = (op == f100_pkg::OP_SUB) || (op == f100_pkg::OP_SBS) ||
             (op == f100_pkg::OP_CMP);
  end

  // Memory operand first, accumulator second.
  // With M set a subtract borrows when C is clear.
  always_comb
  begin
    sum = '0;
    if (is_add)
      sum = {1'b0, d} + {1'b0, a} + {{`F100_WORD_W{1'b0}}, m & c};
    else if (is_sub)
      sum = {1'b0, d} - {1'b0, a} - {{`F100_WORD_W{1'b0}}, m & ~c};
  end

  always_comb
  begin
    case (op)
      f100_pkg::OP_ADD,
      f100_pkg::OP_ADS,
      f100_pkg::OP_SUB,
      f100_pkg::OP_SBS,
      f100_pkg::OP_CMP: result = sum[MSB:0];
      f100_pkg::OP_AND: result = a & d;
      f100_pkg::OP_NEQ: result = a ^ d;
      f100_pkg::OP_STO: result = a;
      default:          result = d;
    endcase
  end

  always_comb
  begin
    flags.carry = sum[`F100_WORD_W];
    flags.sign  = result[MSB];
    flags.zero  = (result == '0);
    if (is_add)
      flags.overflow = (a[MSB] == d[MSB]) && (result[MSB] != a[MSB]);
    else if (is_sub)
      flags.overflow = (a[MSB] != d[MSB]) && (result[MSB] == a[MSB]);
    else
      flags.overflow = 1'b0;
  end

endmodule

//--- hdl/f100_shifter.sv
// F100-L bit operation unit.
// Shifts or rotates one word by the bit index, tests a bit for the
// conditional jumps and sets or clears a single bit.

`timescale 1ns/1ps

module f100_shifter
(
  input  f100_pkg::instr_t instr,
  input  f100_pkg::word_t  d,
  output f100_pkg::word_t  result,
  output logic             jump
);

  localparam int W = $bits(f100_pkg::word_t);

  f100_pkg::bit_fmt_t op;
  logic [2*W-1:0]     twice;
  logic [2*W-1:0]     rot_r;
  logic [2*W-1:0]     rot_l;

  // Rotates come from a doubled copy of the word.
  always_comb
  begin
    op    = instr.bits;
    twice = {d, d};
    rot_r = twice >> op.bit_idx;
    rot_l = twice << op.bit_idx;
  end

  always_comb
  begin
    result = d;
    jump   = 1'b0;
    case (op.s_mode)
      2'b00:
        case (op.j_mode)
          2'b10:   result = d >> op.bit_idx;
          2'b11:   result = rot_r[W-1:0];
          default: result = f100_pkg::word_t'($signed(d) >>> op.bit_idx);
        endcase
      2'b01:
        case (op.j_mode)
          2'b11:   result = rot_l[2*W-1:W];
          default: result = d << op.bit_idx;
        endcase
      2'b10:
      begin
        jump = (d[op.bit_idx] == op.j_mode[0]);
        // jcs and jsc flip the tested bit once it matched.
        if (op.j_mode[1])
          result[op.bit_idx] = ~op.j_mode[0];
      end
      default:
        result[op.bit_idx] = ~op.j_mode[0];
    endcase
  end

endmodule

//--- hdl/f100_control.sv
// F100-L instruction sequencer.
// Holds PC, A, CR, the current instruction and the effective address.
// Fetches and decodes each instruction, generates operand addresses,
// drives the memory bus one access per cycle and writes results back
// to A, CR, PC or memory.

`timescale 1ns/1ps
`include "f100_defines.svh"

module f100_control
(
  input  logic                 raw_clk,
  input  logic                 button_reset,
  input  logic                 button_halt,
  input  f100_pkg::word_t      mem_rdata,
  input  f100_pkg::word_t      alu_result,
  input  f100_pkg::alu_flags_t alu_flags,
  input  f100_pkg::word_t      shift_result,
  input  logic                 shift_jump,
  output f100_pkg::mem_req_t   mem_req,
  output f100_pkg::instr_t     instr,
  output f100_pkg::word_t      operand,
  output f100_pkg::word_t      accum,
  output f100_pkg::cr_t        cr,
  output logic                 halted
);

  localparam int STATE_W = $clog2(`F100_STATE_COUNT);
  localparam int MSB     = `F100_WORD_W - 1;

  typedef enum logic [STATE_W-1:0]
  {
    S_RESET,
    S_FETCH_REQ,
    S_FETCH_CAP,
    S_DECODE,
    S_PTR_READ,
    S_DATA_READ,
    S_EXECUTE,
    S_WRITE_BACK,
    S_JUMP_READ,
    S_HALTED
  } state_e;

  state_e          state;
  f100_pkg::word_t pc;
  f100_pkg::word_t ea;
  f100_pkg::word_t short_addr;
  f100_pkg::word_t ptr_addr;
  logic            short_zero;
  logic            ptr_zero;
  logic            imm_mode;
  logic            v_op;
  logic            cr_sel;
  logic            do_jump;

  // Operand address fields of the current instruction.
  assign short_addr = {{(`F100_WORD_W - `F100_SHORT_W){1'b0}}, instr.alu.addr};
  assign ptr_addr   = f100_pkg::word_t'(instr.alu.addr[7:0]);
  assign short_zero = (instr.alu.addr == '0);
  assign ptr_zero   = (ptr_addr == '0);
  assign imm_mode   = !instr.alu.indirect && short_zero;

  // Only adds and subtracts touch V.
  assign v_op = (instr.alu.op == f100_pkg::OP_ADD) || (instr.alu.op == f100_pkg::OP_ADS) ||
                (instr.alu.op == f100_pkg::OP_SUB) || (instr.alu.op == f100_pkg::OP_SBS) ||
                (instr.alu.op == f100_pkg::OP_CMP);

  // r_mode 01 works on CR, anything else on A.
  assign cr_sel = (instr.bits.r_mode == 2'b01);

  assign halted = (state == S_HALTED);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state                <= S_RESET;
      mem_req.bus_enable   <= 1'b0;
      mem_req.write_enable <= 1'b0;
      do_jump              <= 1'b0;
    end
    else if (!button_halt)
    begin
      state                <= S_HALTED;
      mem_req.bus_enable   <= 1'b0;
      mem_req.write_enable <= 1'b0;
    end
    else
    begin
      case (state)
        S_RESET:
        begin
          pc    <= `F100_RESET_PC;
          accum <= '0;
          cr    <= '0;
          state <= S_FETCH_REQ;
        end
        S_FETCH_REQ:
        begin
          mem_req.address      <= pc;
          mem_req.bus_enable   <= 1'b1;
          mem_req.write_enable <= 1'b0;
          pc                   <= pc + 1'b1;
          state                <= S_FETCH_CAP;
        end
        S_FETCH_CAP:
        begin
          mem_req.bus_enable <= 1'b0;
          instr              <= f100_pkg::instr_t'(mem_rdata);
          state              <= S_DECODE;
        end
        S_DECODE:
        begin
          case (instr.alu.op)
            f100_pkg::OP_BIT:
            begin
              if (instr.bits.sub == `F100_HALT_CODE)
                state <= S_HALTED;
              else
              begin
                operand <= cr_sel ? f100_pkg::word_t'(cr) : accum;
                state   <= S_EXECUTE;
              end
            end
            f100_pkg::OP_STO, f100_pkg::OP_ADS, f100_pkg::OP_SBS,
            f100_pkg::OP_LDA, f100_pkg::OP_ADD, f100_pkg::OP_SUB,
            f100_pkg::OP_CMP, f100_pkg::OP_AND, f100_pkg::OP_NEQ,
            f100_pkg::OP_JMP:
            begin
              mem_req.bus_enable   <= 1'b1;
              mem_req.write_enable <= 1'b0;
              if (!instr.alu.indirect && !short_zero)
              begin
                ea              <= short_addr;
                mem_req.address <= short_addr;
                state           <= S_DATA_READ;
              end
              else if (instr.alu.indirect && !ptr_zero)
              begin
                mem_req.address <= ptr_addr;
                state           <= S_PTR_READ;
              end
              else
              begin
                // Immediate and long forms use the word after the instruction.
                ea              <= pc;
                mem_req.address <= pc;
                pc              <= pc + 1'b1;
                state           <= instr.alu.indirect ? S_PTR_READ : S_DATA_READ;
              end
            end
            default:
              state <= S_FETCH_REQ;
          endcase
        end
        S_PTR_READ:
        begin
          // Bus stays enabled for the data read at the fetched address.
          ea              <= mem_rdata;
          mem_req.address <= mem_rdata;
          state           <= S_DATA_READ;
        end
        S_DATA_READ:
        begin
          mem_req.bus_enable <= 1'b0;
          operand            <= mem_rdata;
          state              <= S_EXECUTE;
        end
        S_EXECUTE:
        begin
          if (instr.alu.op == f100_pkg::OP_BIT)
          begin
            if (cr_sel)
              cr <= f100_pkg::cr_t'(shift_result);
            else
              accum <= shift_result;
            if (instr.bits.s_mode == 2'b10)
            begin
              // The jump target follows the instruction.
              do_jump              <= shift_jump;
              mem_req.address      <= pc;
              mem_req.bus_enable   <= 1'b1;
              mem_req.write_enable <= 1'b0;
              pc                   <= pc + 1'b1;
              state                <= S_JUMP_READ;
            end
            else
            begin
              cr.s  <= shift_result[MSB];
              cr.z  <= (shift_result == '0);
              state <= S_FETCH_REQ;
            end
          end
          else
          begin
            if (instr.alu.op != f100_pkg::OP_LDA)
              cr.c <= alu_flags.carry;
            cr.s <= alu_flags.sign;
            cr.z <= alu_flags.zero;
            if (v_op)
              cr.v <= alu_flags.overflow;
            state <= S_FETCH_REQ;
            case (instr.alu.op)
              f100_pkg::OP_LDA, f100_pkg::OP_ADD, f100_pkg::OP_SUB,
              f100_pkg::OP_AND, f100_pkg::OP_NEQ:
                accum <= alu_result;
              f100_pkg::OP_JMP:
                pc <= imm_mode ? alu_result : ea;
              f100_pkg::OP_STO, f100_pkg::OP_ADS, f100_pkg::OP_SBS:
              begin
                mem_req.address      <= ea;
                mem_req.wdata        <= alu_result;
                mem_req.bus_enable   <= 1'b1;
                mem_req.write_enable <= 1'b1;
                state                <= S_WRITE_BACK;
              end
              default: ;
            endcase
          end
        end
        S_WRITE_BACK:
        begin
          mem_req.bus_enable   <= 1'b0;
          mem_req.write_enable <= 1'b0;
          state                <= S_FETCH_REQ;
        end
        S_JUMP_READ:
        begin
          mem_req.bus_enable <= 1'b0;
          if (do_jump)
            pc <= mem_rdata;
          state <= S_FETCH_REQ;
        end
        S_HALTED:
          state <= S_HALTED;
        default:
          state <= S_RESET;
      endcase
    end
  end

endmodule

//--- hdl/f100_core.sv
// F100-L processor core.
// Joins the sequencer to the ALU and the bit operation unit and
// brings the word-addressed memory bus out to the memory.

`timescale 1ns/1ps
`include "f100_defines.svh"

module f100_core
(
  input  logic               raw_clk,
  input  logic               button_reset,
  input  logic               button_halt,
  input  f100_pkg::word_t    mem_rdata,
  output f100_pkg::mem_req_t mem_req,
  output logic               halted
);

  f100_pkg::instr_t        instr;
  f100_pkg::cr_t           cr;
  f100_pkg::alu_flags_t    alu_flags;
  logic [`F100_WORD_W-1:0] operand;
  logic [`F100_WORD_W-1:0] accum;
  logic [`F100_WORD_W-1:0] alu_result;
  logic [`F100_WORD_W-1:0] shift_result;
  logic                    shift_jump;

  f100_control u_control
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_rdata    (mem_rdata),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .shift_result (shift_result),
    .shift_jump   (shift_jump),
    .mem_req      (mem_req),
    .instr        (instr),
    .operand      (operand),
    .accum        (accum),
    .cr           (cr),
    .halted       (halted)
  );

  f100_alu u_alu
  (
    .op     (instr.alu.op),
    .a      (accum),
    .d      (operand),
    .m      (cr.m),
    .c      (cr.c),
    .result (alu_result),
    .flags  (alu_flags)
  );

  f100_shifter u_shifter
  (
    .instr  (instr),
    .d      (operand),
    .result (shift_result),
    .jump   (shift_jump)
  );

endmodule

//--- sim/f100_tb.sv
// F100-L core testbench.
// Runs short directed programs from a word-addressed memory model and
// checks stored results, flags seen through bit jumps, shifts, operand
// addressing, the reset sequence and both ways of halting the core.

`timescale 1ns/1ps
`include "f100_defines.svh"

module f100_tb;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 10;
  localparam int          TEST_COUNT   = 6;
  localparam int          TEST_CYCLES  = 400;
  localparam logic [15:0] HALT_INSTR   = {4'h0, `F100_HALT_CODE, 10'h000};

  logic               raw_clk;
  logic               button_reset;
  logic               button_halt;
  f100_pkg::word_t    mem_rdata;
  f100_pkg::mem_req_t mem_req;
  logic               halted;

  logic [15:0] mem [0:65535];
  logic [15:0] rd_log [$];
  logic [15:0] lfsr_state;
  logic [15:0] prog_ptr;
  logic [15:0] last_wr_addr;
  int          wr_count;
  int          access_count;
  int          mismatches;
  int          failures;

  f100_core dut
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .halted       (halted)
  );

  always #(CLK_PERIOD / 2) raw_clk = ~raw_clk;

  // Memory answers reads at once and stores writes at the closing edge.
  assign mem_rdata = mem[mem_req.address];

  always @(posedge raw_clk)
  begin
    if (mem_req.bus_enable === 1'b1)
    begin
      access_count++;
      if (mem_req.write_enable === 1'b1)
      begin
        mem[mem_req.address] <= mem_req.wdata;
        last_wr_addr = mem_req.address;
        wr_count++;
      end
      else
        rd_log.push_back(mem_req.address);
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  task automatic random_bits(input int nbits, output logic [15:0] val);
    int i;
    val = '0;
    for (i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [15:0] mem_ref(input f100_pkg::alu_op_e op, input logic ind,
                                          input logic [10:0] addr);
    return {op, ind, addr};
  endfunction

  function automatic logic [15:0] bit_op(input logic [1:0] r, input logic [1:0] s,
                                         input logic [1:0] j, input logic [3:0] idx);
    return {4'h0, 2'b00, r, s, j, idx};
  endfunction

  // Bit-serial model of the shift rules.
  function automatic logic [15:0] shift_ref(input logic [1:0] s, input logic [1:0] j,
                                            input logic [15:0] v, input logic [3:0] n);
    logic [15:0] r;
    int          i;
    r = v;
    for (i = 0; i < n; i++)
    begin
      if (s == 2'b00)
        case (j)
          2'b10:   r = {1'b0, r[15:1]};
          2'b11:   r = {r[0], r[15:1]};
          default: r = {r[15], r[15:1]};
        endcase
      else if (j == 2'b11)
        r = {r[14:0], r[15]};
      else
        r = {r[14:0], 1'b0};
    end
    return r;
  endfunction

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: %s expected 0x%04h, got 0x%04h", $time, name, exp, got);
    end
  endtask

  task automatic check_condition(input logic ok, input string what);
    assert (ok === 1'b1)
    else
    begin
      failures++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // Holds the core in reset and fills memory before a new program.
  task automatic begin_program();
    int i;
    @(posedge raw_clk);
    #1;
    button_reset = 1'b0;
    button_halt  = 1'b1;
    for (i = 0; i < 65536; i++)
      mem[i] = i[15:0] ^ 16'hc35a;
    prog_ptr = `F100_RESET_PC;
  endtask

  task automatic emit(input logic [15:0] w);
    mem[prog_ptr] = w;
    prog_ptr++;
  endtask

  task automatic release_reset();
    repeat (RESET_CYCLES) @(posedge raw_clk);
    #1;
    wr_count     = 0;
    access_count = 0;
    rd_log.delete();
    button_reset = 1'b1;
  endtask

  task automatic run_to_halt(input int limit);
    int n;
    n = 0;
    while (halted !== 1'b1 && n < limit)
    begin
      @(posedge raw_clk);
      #1;
      n++;
    end
    check_condition(halted, "core did not halt within the cycle limit");
  endtask

  task automatic test_reset();
    int n;
    begin_program();
    emit(HALT_INSTR);
    release_reset();
    check_condition(mem_req.bus_enable === 1'b0 && mem_req.write_enable === 1'b0,
                    "bus strobes not low after reset");
    check_condition(halted === 1'b0, "halted not low after reset");
    n = 0;
    while (mem_req.bus_enable !== 1'b1 && n < 3)
    begin
      @(posedge raw_clk);
      #1;
      n++;
    end
    check_condition(mem_req.bus_enable, "no bus access within 3 cycles of reset release");
    check_condition(mem_req.write_enable === 1'b0, "first access after reset is not a read");
    check_word("mem_req.address", mem_req.address, `F100_RESET_PC);
    run_to_halt(50);
  endtask

  task automatic test_arith_logic();
    logic [15:0] a, b, c, d, e, acc;
    random_bits(16, a);
    random_bits(16, b);
    random_bits(16, c);
    random_bits(16, d);
    random_bits(16, e);
    begin_program();
    emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
    emit(a);
    emit(mem_ref(f100_pkg::OP_ADD, 1'b0, 11'h000));
    emit(b);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h101));
    emit(mem_ref(f100_pkg::OP_SUB, 1'b0, 11'h000));
    emit(c);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h102));
    emit(mem_ref(f100_pkg::OP_AND, 1'b0, 11'h000));
    emit(d);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h103));
    emit(mem_ref(f100_pkg::OP_NEQ, 1'b0, 11'h000));
    emit(e);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h104));
    emit(HALT_INSTR);
    release_reset();
    run_to_halt(200);
    // Memory operand minus A for SUB.
    acc = b + a;
    check_word("mem[0x0101] after ADD", mem[16'h0101], acc);
    acc = c - acc;
    check_word("mem[0x0102] after SUB", mem[16'h0102], acc);
    acc = acc & d;
    check_word("mem[0x0103] after AND", mem[16'h0103], acc);
    acc = acc ^ e;
    check_word("mem[0x0104] after NEQ", mem[16'h0104], acc);
  endtask

  task automatic test_flags();
    logic [15:0] a, b, x, y, diff;
    logic [3:0]  idx;
    logic        flag;
    logic        taken;
    logic        carry_in;
    int          i;
    for (i = 0; i < 6; i++)
    begin
      random_bits(16, a);
      random_bits(16, b);
      if (i == 0)
        b = a;
      diff = b - a;
      case (i % 3)
        0:
        begin
          idx  = 4'd1;
          flag = (a == b);
        end
        1:
        begin
          idx  = 4'd3;
          flag = diff[15];
        end
        default:
        begin
          idx  = 4'd4;
          flag = (b < a);
        end
      endcase
      // First three use jbs, the rest jbc.
      taken = (i < 3) ? flag : !flag;
      begin_program();
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(a);
      emit(mem_ref(f100_pkg::OP_CMP, 1'b0, 11'h000));
      emit(b);
      emit(bit_op(2'b01, 2'b10, (i < 3) ? 2'b01 : 2'b00, idx));
      emit(`F100_RESET_PC + 16'd8);
      emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h100));
      emit(HALT_INSTR);
      emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h101));
      emit(HALT_INSTR);
      release_reset();
      run_to_halt(100);
      check_condition(wr_count == 1, "bit jump program did not store exactly once");
      check_word("store address after bit jump", last_wr_addr,
                 taken ? 16'h0101 : 16'h0100);
    end
    // Carry from CMP feeds ADD once M is set.
    for (i = 0; i < 2; i++)
    begin
      random_bits(16, a);
      random_bits(16, b);
      random_bits(16, x);
      random_bits(16, y);
      if (i == 0)
      begin
        a = a | 16'h8000;
        b = b & 16'h7fff;
      end
      else
      begin
        a = a & 16'h7fff;
        b = b | 16'h8000;
      end
      carry_in = (b < a);
      begin_program();
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(a);
      emit(mem_ref(f100_pkg::OP_CMP, 1'b0, 11'h000));
      emit(b);
      emit(bit_op(2'b01, 2'b11, 2'b00, 4'd5));
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(x);
      emit(mem_ref(f100_pkg::OP_ADD, 1'b0, 11'h000));
      emit(y);
      emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h102));
      // CMP leaves C set when b < a, then M is cleared so ADD ignores it.
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(a);
      emit(mem_ref(f100_pkg::OP_CMP, 1'b0, 11'h000));
      emit(b);
      emit(bit_op(2'b01, 2'b11, 2'b01, 4'd5));
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(x);
      emit(mem_ref(f100_pkg::OP_ADD, 1'b0, 11'h000));
      emit(y);
      emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h103));
      emit(HALT_INSTR);
      release_reset();
      run_to_halt(160);
      check_word("mem[0x0102] after ADD with carry", mem[16'h0102], x + y + carry_in);
      check_word("mem[0x0103] after ADD with M clear", mem[16'h0103], x + y);
    end
  endtask

  task automatic test_shifts();
    logic [15:0] vals [6];
    logic [15:0] amt;
    logic [3:0]  amounts [6];
    logic [1:0]  s_tab [6];
    logic [1:0]  j_tab [6];
    int          k;
    s_tab = '{2'b00, 2'b00, 2'b00, 2'b00, 2'b01, 2'b01};
    j_tab = '{2'b00, 2'b01, 2'b10, 2'b11, 2'b00, 2'b11};
    begin_program();
    for (k = 0; k < 6; k++)
    begin
      random_bits(16, vals[k]);
      random_bits(4, amt);
      amounts[k] = amt[3:0];
      emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
      emit(vals[k]);
      emit(bit_op(2'b00, s_tab[k], j_tab[k], amounts[k]));
      emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h100 + k));
    end
    emit(HALT_INSTR);
    release_reset();
    run_to_halt(250);
    for (k = 0; k < 6; k++)
      check_word($sformatf("mem[0x%04h] after shift", 16'h0100 + k), mem[16'h0100 + k],
                 shift_ref(s_tab[k], j_tab[k], vals[k], amounts[k]));
  endtask

  task automatic test_addressing();
    logic [15:0] x, y, p, v1, v2;
    int          i;
    int          found;
    random_bits(12, x);
    random_bits(12, y);
    random_bits(6, p);
    random_bits(16, v1);
    random_bits(16, v2);
    x = x | 16'h3000;
    y = y | 16'h4000;
    p = p | 16'h0040;
    begin_program();
    emit(mem_ref(f100_pkg::OP_LDA, 1'b1, 11'h000));
    emit(x);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h101));
    emit(mem_ref(f100_pkg::OP_LDA, 1'b1, p[10:0]));
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h102));
    emit(mem_ref(f100_pkg::OP_JMP, 1'b0, 11'h000));
    emit(16'h2100);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h103));
    emit(HALT_INSTR);
    mem[16'h2100] = HALT_INSTR;
    mem[x] = v1;
    mem[p] = y;
    mem[y] = v2;
    release_reset();
    run_to_halt(150);
    check_word("mem[0x0101] after LDA .W", mem[16'h0101], v1);
    check_word("mem[0x0102] after LDA [P]", mem[16'h0102], v2);
    check_condition(wr_count == 2, "store after JMP was executed");
    found = -1;
    for (i = 0; i < rd_log.size(); i++)
      if (rd_log[i] == 16'h2006)
        found = i;
    check_condition(found >= 0 && found + 1 < rd_log.size(),
                    "no fetch followed the JMP operand read");
    if (found >= 0 && found + 1 < rd_log.size())
      check_word("fetch address after JMP", rd_log[found + 1], 16'h2100);
  endtask

  task automatic test_halt();
    logic [15:0] v;
    int          seen;
    int          n;
    random_bits(16, v);
    begin_program();
    emit(mem_ref(f100_pkg::OP_LDA, 1'b0, 11'h000));
    emit(v);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h100));
    emit(HALT_INSTR);
    emit(mem_ref(f100_pkg::OP_STO, 1'b0, 11'h101));
    release_reset();
    run_to_halt(100);
    check_word("mem[0x0100] before halt", mem[16'h0100], v);
    seen = access_count;
    repeat (20) @(posedge raw_clk);
    #1;
    check_condition(access_count == seen, "bus access after halt instruction");
    check_condition(wr_count == 1, "store after halt instruction was executed");
    check_condition(halted, "halted dropped without reset");
    // Endless jump loop stopped by the button.
    begin_program();
    emit(mem_ref(f100_pkg::OP_JMP, 1'b0, 11'h000));
    emit(`F100_RESET_PC);
    release_reset();
    repeat (15) @(posedge raw_clk);
    #1;
    check_condition(halted === 1'b0, "core halted before button_halt was pulled");
    button_halt = 1'b0;
    n = 0;
    while (halted !== 1'b1 && n < 3)
    begin
      @(posedge raw_clk);
      #1;
      n++;
    end
    check_condition(halted, "button_halt did not halt the core");
    seen = access_count;
    repeat (20) @(posedge raw_clk);
    #1;
    check_condition(access_count == seen, "bus access after button_halt");
    button_halt = 1'b1;
  endtask

  initial
  begin
    #(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
    $display("Error at %0t: watchdog timeout, tests did not finish", $time);
    $display("Closing: %0d mismatches, %0d other failures", mismatches, failures + 1);
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    raw_clk      = 1'b0;
    button_reset = 1'b0;
    button_halt  = 1'b1;
    lfsr_state   = 16'd25;
    mismatches   = 0;
    failures     = 0;
    wr_count     = 0;
    access_count = 0;
    test_reset();
    test_arith_logic();
    test_flags();
    test_shifts();
    test_addressing();
    test_halt();
    $display("Closing: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/f100_pkg.sv
hdl/f100_alu.sv
hdl/f100_shifter.sv
hdl/f100_control.sv
hdl/f100_core.sv
sim/f100_tb.sv

//--- Bender.yml
package:
  name: f100_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/f100_pkg.sv
      - hdl/f100_alu.sv
      - hdl/f100_shifter.sv
      - hdl/f100_control.sv
      - hdl/f100_core.sv
  - target: test
    files:
      - sim/f100_tb.sv
